// ==== src/soc_pkg.sv ====
/*
 * Shared bus types, memory map and register layout of the peripheral system.
 * Wishbone classic only; no retry, error or burst lines.
 * The region field is address bits 31:17, so each slave sees a 128 KiB window.
 */

package soc_pkg;

	// ------------------------------
	// Bus types
	// ------------------------------
	typedef logic [31:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0]  wb_sel_t;

	// Region field of the address, bits 31:MAP_SHIFT
	typedef logic [14:0] region_t;

	// Register offset inside a slave window
	typedef logic [7:0]  reg_ofs_t;

	// Active low, one bit per interrupt source
	typedef logic [31:0] irq_vec_t;

	// Master request, 71 bits
	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		wb_adr_t adr;
		wb_sel_t sel;
		wb_dat_t dat;
	} wb_req_t;

	// Slave response, 33 bits
	typedef struct packed {
		logic    ack;
		wb_dat_t dat;
	} wb_rsp_t;

	// Decoder targets
	typedef enum logic [1:0] {
		SLV_BRAM,
		SLV_TIMER,
		SLV_GPIO,
		SLV_NONE
	} slave_sel_t;

	// ------------------------------
	// Memory map
	// ------------------------------
	localparam int      MAP_SHIFT    = 17;
	localparam region_t REGION_BRAM  = 15'h0000;
	localparam region_t REGION_TIMER = 15'h7001;
	localparam region_t REGION_GPIO  = 15'h7002;

	// Timer registers, two identical sets of three words
	localparam reg_ofs_t TIMER_TCR0_OFS = 8'h00;
	localparam reg_ofs_t TIMER_CMP0_OFS = 8'h04;
	localparam reg_ofs_t TIMER_CNT0_OFS = 8'h08;
	localparam reg_ofs_t TIMER_TCR1_OFS = 8'h0C;
	localparam reg_ofs_t TIMER_CMP1_OFS = 8'h10;
	localparam reg_ofs_t TIMER_CNT1_OFS = 8'h14;

	// Timer control bits
	localparam int TCR_EN_BIT    = 0;
	localparam int TCR_AR_BIT    = 1;
	localparam int TCR_IRQEN_BIT = 2;
	localparam int TCR_FLAG_BIT  = 3;

	// GPIO registers
	localparam reg_ofs_t GPIO_IN_OFS    = 8'h00;
	localparam reg_ofs_t GPIO_OUT_OFS   = 8'h04;
	localparam reg_ofs_t GPIO_OE_OFS    = 8'h08;
	localparam reg_ofs_t GPIO_IMASK_OFS = 8'h0C;
	localparam int       GPIO_BTN_LSB   = 8;

	// Interrupt vector positions
	localparam int IRQ_UART   = 0;
	localparam int IRQ_TIMER0 = 1;
	localparam int IRQ_GPIO   = 2;
	localparam int IRQ_TIMER1 = 3;

endpackage

// ==== src/soc_bus_decoder.sv ====
/*
 * Single master address decoder on the region field.
 * Unmapped regions get a one cycle ack with zero data, so the bus never hangs.
 * The master must hold the request until ack, which keeps the response mux valid.
 */

`timescale 1ns/1ps

module soc_bus_decoder (
	input  logic             clk,
	input  logic             reset_i,
	input  soc_pkg::wb_req_t m_req_i,
	output soc_pkg::wb_rsp_t m_rsp_o,
	output soc_pkg::wb_req_t bram_req_o,
	input  soc_pkg::wb_rsp_t bram_rsp_i,
	output soc_pkg::wb_req_t timer_req_o,
	input  soc_pkg::wb_rsp_t timer_rsp_i,
	output soc_pkg::wb_req_t gpio_req_o,
	input  soc_pkg::wb_rsp_t gpio_rsp_i
);

	soc_pkg::slave_sel_t slave_sel;
	soc_pkg::region_t    region;
	logic                none_ack_q;

	// Pass the request on, but only the hit slave sees cyc and stb
	function automatic soc_pkg::wb_req_t gate_req(soc_pkg::wb_req_t r, logic hit);
		soc_pkg::wb_req_t g;
		g = r;
		g.cyc = r.cyc & hit;
		g.stb = r.stb & hit;
		return g;
	endfunction

	// ------------------------------
	// Region decode
	// ------------------------------
	assign region = m_req_i.adr[31:soc_pkg::MAP_SHIFT];

	always_comb begin
		case (region)
			soc_pkg::REGION_BRAM:  slave_sel = soc_pkg::SLV_BRAM;
			soc_pkg::REGION_TIMER: slave_sel = soc_pkg::SLV_TIMER;
			soc_pkg::REGION_GPIO:  slave_sel = soc_pkg::SLV_GPIO;
			default:               slave_sel = soc_pkg::SLV_NONE;
		endcase
	end

	assign bram_req_o  = gate_req(m_req_i, slave_sel == soc_pkg::SLV_BRAM);
	assign timer_req_o = gate_req(m_req_i, slave_sel == soc_pkg::SLV_TIMER);
	assign gpio_req_o  = gate_req(m_req_i, slave_sel == soc_pkg::SLV_GPIO);

	// ------------------------------
	// Default slave
	// ------------------------------
	// Same one cycle ack as the real slaves
	always_ff @(posedge clk) begin
		if (reset_i) begin
			none_ack_q <= 1'b0;
		end else begin
			none_ack_q <= m_req_i.cyc & m_req_i.stb & ~none_ack_q
				& (slave_sel == soc_pkg::SLV_NONE);
		end
	end

	// Response mux
	always_comb begin
		case (slave_sel)
			soc_pkg::SLV_BRAM:  m_rsp_o = bram_rsp_i;
			soc_pkg::SLV_TIMER: m_rsp_o = timer_rsp_i;
			soc_pkg::SLV_GPIO:  m_rsp_o = gpio_rsp_i;
			default: begin
				m_rsp_o.ack = none_ack_q;
				m_rsp_o.dat = '0;
			end
		endcase
	end

endmodule

// ==== src/soc_bram.sv ====
/*
 * Word-wide block RAM of 2**BRAM_ADR_W bytes with byte-lane writes.
 * Address bits above BRAM_ADR_W-1 are ignored, so the RAM wraps in its window.
 * No preload; contents are undefined until written.
 */

`timescale 1ns/1ps

module soc_bram #(
	parameter int BRAM_ADR_W = 12
) (
	input  logic             clk,
	input  logic             reset_i,
	input  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o
);

	localparam int WORDS = 2 ** (BRAM_ADR_W - 2);

	soc_pkg::wb_dat_t        mem [WORDS];
	logic [BRAM_ADR_W-3:0]   word_idx;
	logic                    access;
	logic                    ack_q;
	soc_pkg::wb_dat_t        rd_dat_q;

	// Word index, byte offset dropped
	assign word_idx = req_i.adr[BRAM_ADR_W-1:2];

	// New access only while our own ack is low
	assign access = req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// ------------------------------
	// Storage
	// ------------------------------
	always_ff @(posedge clk) begin
		if (access & req_i.we) begin
			for (int i = 0; i < 4; i++) begin
				// Enabled lanes only
				if (req_i.sel[i]) begin
					mem[word_idx][8*i +: 8] <= req_i.dat[8*i +: 8];
				end
			end
		end
		// Read data lines up with ack
		if (access) begin
			rd_dat_q <= mem[word_idx];
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = rd_dat_q;

endmodule

// ==== src/soc_timer.sv ====
/*
 * Two compare timers, counting one step per clock while enabled.
 * Writes are full words; sel is ignored. Any control write clears the flag.
 * One-shot mode stops at the compare value, auto-reload restarts from 0.
 */

`timescale 1ns/1ps

module soc_timer (
	input  logic             clk,
	input  logic             reset_i,
	input  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	output logic [1:0]       irq_o
);

	logic              access;
	logic              wr;
	logic              ack_q;
	soc_pkg::reg_ofs_t ofs;
	logic [1:0]        en_q, ar_q, irqen_q, flag_q;
	logic [1:0]        tcr_wr, cmp_wr, cnt_wr;
	soc_pkg::wb_dat_t  cmp_q [2];
	soc_pkg::wb_dat_t  cnt_q [2];
	soc_pkg::wb_dat_t  tcr_val [2];
	soc_pkg::wb_dat_t  rd_dat, rd_dat_q;

	assign access = req_i.cyc & req_i.stb & ~ack_q;
	assign wr     = access & req_i.we;
	assign ofs    = req_i.adr[7:0];

	// ------------------------------
	// Register decode
	// ------------------------------
	always_comb begin
		tcr_wr = '0;
		cmp_wr = '0;
		cnt_wr = '0;
		if (wr) begin
			case (ofs)
				soc_pkg::TIMER_TCR0_OFS: tcr_wr[0] = 1'b1;
				soc_pkg::TIMER_CMP0_OFS: cmp_wr[0] = 1'b1;
				soc_pkg::TIMER_CNT0_OFS: cnt_wr[0] = 1'b1;
				soc_pkg::TIMER_TCR1_OFS: tcr_wr[1] = 1'b1;
				soc_pkg::TIMER_CMP1_OFS: cmp_wr[1] = 1'b1;
				soc_pkg::TIMER_CNT1_OFS: cnt_wr[1] = 1'b1;
				default: ;
			endcase
		end
	end

	// ------------------------------
	// Counters
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_q   <= 1'b0;
			en_q    <= '0;
			ar_q    <= '0;
			irqen_q <= '0;
			flag_q  <= '0;
			cmp_q   <= '{default: '0};
			cnt_q   <= '{default: '0};
		end else begin
			ack_q <= access;
			for (int t = 0; t < 2; t++) begin
				if (tcr_wr[t]) begin
					// Control write wins over the compare hit
					en_q[t]    <= req_i.dat[soc_pkg::TCR_EN_BIT];
					ar_q[t]    <= req_i.dat[soc_pkg::TCR_AR_BIT];
					irqen_q[t] <= req_i.dat[soc_pkg::TCR_IRQEN_BIT];
					flag_q[t]  <= 1'b0;
				end else if (en_q[t]) begin
					if (cnt_q[t] == cmp_q[t]) begin
						flag_q[t] <= 1'b1;
						if (ar_q[t])
							cnt_q[t] <= '0;
						else
							en_q[t] <= 1'b0;   // one-shot holds the count
					end else begin
						cnt_q[t] <= cnt_q[t] + 1'b1;
					end
				end
				if (cmp_wr[t])
					cmp_q[t] <= req_i.dat;
				// Bus write to the counter overrides counting
				if (cnt_wr[t])
					cnt_q[t] <= req_i.dat;
			end
		end
	end

	// ------------------------------
	// Read back
	// ------------------------------
	always_comb begin
		for (int t = 0; t < 2; t++) begin
			tcr_val[t] = '0;
			tcr_val[t][soc_pkg::TCR_EN_BIT]    = en_q[t];
			tcr_val[t][soc_pkg::TCR_AR_BIT]    = ar_q[t];
			tcr_val[t][soc_pkg::TCR_IRQEN_BIT] = irqen_q[t];
			tcr_val[t][soc_pkg::TCR_FLAG_BIT]  = flag_q[t];
		end
		case (ofs)
			soc_pkg::TIMER_TCR0_OFS: rd_dat = tcr_val[0];
			soc_pkg::TIMER_CMP0_OFS: rd_dat = cmp_q[0];
			soc_pkg::TIMER_CNT0_OFS: rd_dat = cnt_q[0];
			soc_pkg::TIMER_TCR1_OFS: rd_dat = tcr_val[1];
			soc_pkg::TIMER_CMP1_OFS: rd_dat = cmp_q[1];
			soc_pkg::TIMER_CNT1_OFS: rd_dat = cnt_q[1];
			default:                 rd_dat = '0;
		endcase
	end

	// Payload only, valid with ack
	always_ff @(posedge clk) begin
		if (access)
			rd_dat_q <= rd_dat;
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = rd_dat_q;
	assign irq_o     = flag_q & irqen_q;

endmodule

// ==== src/soc_gpio.sv ====
/*
 * GPIO registers plus the board LED and button routing.
 * sw_i[1] high: buttons feed inputs 11:8 and LEDs show OUT bits 7:0.
 * sw_i[1] low: inputs read 0 and LEDs show bus and interrupt activity.
 * Writes are full words; OE has no pin and only reads back.
 */

`timescale 1ns/1ps

module soc_gpio (
	input  logic             clk,
	input  logic             reset_i,
	input  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	input  soc_pkg::wb_req_t bus_req_i,
	input  soc_pkg::wb_rsp_t bus_rsp_i,
	input  logic [1:0]       timer_irq_i,
	input  logic [3:0]       sw_i,
	input  logic [3:0]       btn_i,
	output logic [7:0]       led_o,
	output logic             irq_o
);

	logic              access;
	logic              ack_q;
	soc_pkg::reg_ofs_t ofs;
	soc_pkg::wb_dat_t  in_raw;
	soc_pkg::wb_dat_t  in_q, out_q, oe_q, imask_q;
	soc_pkg::wb_dat_t  rd_dat_q;
	logic [7:0]        debug_leds;

	assign access = req_i.cyc & req_i.stb & ~ack_q;
	assign ofs    = req_i.adr[7:0];

	// Buttons reach the input register only in GPIO mode
	always_comb begin
		in_raw = '0;
		if (sw_i[1])
			in_raw[soc_pkg::GPIO_BTN_LSB +: 4] = btn_i;
	end

	// ------------------------------
	// Registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_q   <= 1'b0;
			in_q    <= '0;
			out_q   <= '0;
			oe_q    <= '0;
			imask_q <= '0;
		end else begin
			ack_q <= access;
			in_q  <= in_raw;     // single sync stage
			if (access & req_i.we) begin
				case (ofs)
					soc_pkg::GPIO_OUT_OFS:   out_q   <= req_i.dat;
					soc_pkg::GPIO_OE_OFS:    oe_q    <= req_i.dat;
					soc_pkg::GPIO_IMASK_OFS: imask_q <= req_i.dat;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			case (ofs)
				soc_pkg::GPIO_IN_OFS:    rd_dat_q <= in_q;
				soc_pkg::GPIO_OUT_OFS:   rd_dat_q <= out_q;
				soc_pkg::GPIO_OE_OFS:    rd_dat_q <= oe_q;
				soc_pkg::GPIO_IMASK_OFS: rd_dat_q <= imask_q;
				default:                 rd_dat_q <= '0;
			endcase
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = rd_dat_q;

	// Level interrupt on any unmasked input
	assign irq_o = |(in_q & imask_q);

	// ------------------------------
	// LEDs
	// ------------------------------
	// MSB first: cyc, stb, we, ack, timer1, gpio, timer0, 0
	assign debug_leds = {bus_req_i.cyc, bus_req_i.stb, bus_req_i.we, bus_rsp_i.ack,
		timer_irq_i[1], irq_o, timer_irq_i[0], 1'b0};

	assign led_o = sw_i[1] ? out_q[7:0] : debug_leds;

endmodule

// ==== src/soc_top.sv ====
/*
 * Peripheral system top: one external Wishbone master, RAM, timers and GPIO.
 * The interrupt vector is active low; the UART bit stays high (no UART here).
 */

`timescale 1ns/1ps

module soc_top #(
	parameter int BRAM_ADR_W = 12
) (
	input  logic              clk,
	input  logic              reset_i,
	input  soc_pkg::wb_req_t  bus_req_i,
	output soc_pkg::wb_rsp_t  bus_rsp_o,
	input  logic [3:0]        sw_i,
	input  logic [3:0]        btn_i,
	output logic [7:0]        led_o,
	output soc_pkg::irq_vec_t intr_n_o
);

	soc_pkg::wb_req_t bram_req, timer_req, gpio_req;
	soc_pkg::wb_rsp_t bram_rsp, timer_rsp, gpio_rsp;
	logic [1:0]       timer_irq;
	logic             gpio_irq;

	// ------------------------------
	// Interconnect
	// ------------------------------
	soc_bus_decoder decoder_i (
		.clk         (clk),
		.reset_i     (reset_i),
		.m_req_i     (bus_req_i),
		.m_rsp_o     (bus_rsp_o),
		.bram_req_o  (bram_req),
		.bram_rsp_i  (bram_rsp),
		.timer_req_o (timer_req),
		.timer_rsp_i (timer_rsp),
		.gpio_req_o  (gpio_req),
		.gpio_rsp_i  (gpio_rsp)
	);

	// ------------------------------
	// Slaves
	// ------------------------------
	soc_bram #(
		.BRAM_ADR_W (BRAM_ADR_W)
	) bram_i (
		.clk     (clk),
		.reset_i (reset_i),
		.req_i   (bram_req),
		.rsp_o   (bram_rsp)
	);

	soc_timer timer_i (
		.clk     (clk),
		.reset_i (reset_i),
		.req_i   (timer_req),
		.rsp_o   (timer_rsp),
		.irq_o   (timer_irq)
	);

	// Debug LEDs watch the master side of the bus
	soc_gpio gpio_i (
		.clk         (clk),
		.reset_i     (reset_i),
		.req_i       (gpio_req),
		.rsp_o       (gpio_rsp),
		.bus_req_i   (bus_req_i),
		.bus_rsp_i   (bus_rsp_o),
		.timer_irq_i (timer_irq),
		.sw_i        (sw_i),
		.btn_i       (btn_i),
		.led_o       (led_o),
		.irq_o       (gpio_irq)
	);

	// Unused sources stay inactive high
	always_comb begin
		intr_n_o = '1;
		intr_n_o[soc_pkg::IRQ_TIMER0] = ~timer_irq[0];
		intr_n_o[soc_pkg::IRQ_GPIO]   = ~gpio_irq;
		intr_n_o[soc_pkg::IRQ_TIMER1] = ~timer_irq[1];
	end

endmodule

// ==== tb/tb_clock.sv ====
/*
 * Clock and reset source for the testbench.
 * 20 ns period; reset_o is high for the first 4 rising edges.
 */

`timescale 1ns/1ps

module tb_clock (
	output logic clk_o,
	output logic reset_o
);

	// Half period in ns
	localparam int HALF_PERIOD = 10;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	// Synchronous reset, released on a rising edge
	initial begin
		reset_o <= 1'b1;
		repeat (4) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

// ==== tb/soc_props.sv ====
/*
 * Bus handshake and interrupt vector properties, bound into soc_top.
 * Checked only while reset is low.
 */

`timescale 1ns/1ps

module soc_props (
	input logic              clk,
	input logic              reset_i,
	input soc_pkg::wb_req_t  req_i,
	input soc_pkg::wb_rsp_t  rsp_i,
	input soc_pkg::irq_vec_t intr_n_i
);

	// Ack is a single cycle pulse
	ack_pulse_a: assert property (@(posedge clk) disable iff (reset_i)
		rsp_i.ack |=> !rsp_i.ack)
		else $error("bus ack high for two cycles in a row");

	// Ack only answers a live request
	ack_cause_a: assert property (@(posedge clk) disable iff (reset_i)
		$rose(rsp_i.ack) |-> $past(req_i.cyc && req_i.stb))
		else $error("bus ack without a preceding cyc and stb");

	// No UART in this system, its bit never goes low
	uart_idle_a: assert property (@(posedge clk) disable iff (reset_i)
		intr_n_i[soc_pkg::IRQ_UART])
		else $error("UART interrupt bit driven low");

endmodule

bind soc_top soc_props props_i (
	.clk      (clk),
	.reset_i  (reset_i),
	.req_i    (bus_req_i),
	.rsp_i    (bus_rsp_o),
	.intr_n_i (intr_n_o)
);

// ==== tb/tb_soc.sv ====
/*
 * Testbench for soc_top; the testbench is the only Wishbone master.
 * One access at a time, each waiting for ack with a short timeout.
 * Expected values come from the reference functions below.
 */

`timescale 1ns/1ps

module tb_soc;

	localparam int RAM_ADR_W    = 12;
	localparam int RAM_WORDS    = 2 ** (RAM_ADR_W - 2);
	localparam int ACK_TIMEOUT  = 16;
	localparam int SLOTS        = 16;
	localparam int RAM_WRITES   = 64;
	localparam int MAX_POLLS    = 100;
	localparam int RELOAD_READS = 20;

	// Cycle budget per test with about three cycles per access
	localparam int RESET_CYCLES   = 50;
	localparam int BRAM_CYCLES    = 1500;
	localparam int UNMAP_CYCLES   = 250;
	localparam int ONESHOT_CYCLES = 1900;
	localparam int RELOAD_CYCLES  = 800;
	localparam int GPIO_CYCLES    = 500;
	localparam int CYCLE_LIMIT    = 4 * (RESET_CYCLES + BRAM_CYCLES + UNMAP_CYCLES
		+ ONESHOT_CYCLES + RELOAD_CYCLES + GPIO_CYCLES);

	localparam soc_pkg::wb_dat_t ONESHOT_CMP = 32'd40;
	localparam soc_pkg::wb_dat_t RELOAD_CMP  = 32'd25;

	logic              clk;
	logic              reset_i;
	soc_pkg::wb_req_t  bus_req;
	soc_pkg::wb_rsp_t  bus_rsp;
	logic [3:0]        sw;
	logic [3:0]        btn;
	logic [7:0]        led;
	soc_pkg::irq_vec_t intr_n;

	// Run state
	int          errors      = 0;
	int          checks      = 0;
	int          test_errors = 0;
	int          test_checks = 0;
	int          pending     = 0;
	int          cycle_cnt   = 0;
	string       test_name;
	logic [31:0] lcg_state;
	// LED byte seen while the last access was acknowledged
	logic [7:0]  led_at_ack;

	// Compare queue, filled by the tests
	event             cmp_ev;
	string            name_q[$];
	soc_pkg::wb_dat_t got_q[$];
	soc_pkg::wb_dat_t exp_q[$];
	string            cmp_name;
	soc_pkg::wb_dat_t cmp_got;
	soc_pkg::wb_dat_t cmp_exp;

	// RAM model with one word per test slot
	soc_pkg::wb_adr_t slot_adr[SLOTS];
	soc_pkg::wb_dat_t ram_model[SLOTS];

	tb_clock clock_i (
		.clk_o   (clk),
		.reset_o (reset_i)
	);

	soc_top #(
		.BRAM_ADR_W (RAM_ADR_W)
	) soc_top_i (
		.clk       (clk),
		.reset_i   (reset_i),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.sw_i      (sw),
		.btn_i     (btn),
		.led_o     (led),
		.intr_n_o  (intr_n)
	);

	// ------------------------------
	// Reference functions
	// ------------------------------
	// LCG step with the halves swapped so the weak low bits end up on top
	function automatic soc_pkg::wb_dat_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {lcg_state[15:0], lcg_state[31:16]};
	endfunction

	// Byte-lane write into an old RAM word
	function automatic soc_pkg::wb_dat_t merge_lanes(soc_pkg::wb_dat_t old_w,
		soc_pkg::wb_dat_t new_w, soc_pkg::wb_sel_t sel);
		soc_pkg::wb_dat_t res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	function automatic soc_pkg::wb_dat_t tcr_expect(logic en, logic ar, logic irqen,
		logic flag);
		soc_pkg::wb_dat_t w;
		w = '0;
		w[soc_pkg::TCR_EN_BIT]    = en;
		w[soc_pkg::TCR_AR_BIT]    = ar;
		w[soc_pkg::TCR_IRQEN_BIT] = irqen;
		w[soc_pkg::TCR_FLAG_BIT]  = flag;
		return w;
	endfunction

	// bus_bits is cyc, stb, we, ack; irq_bits is timer1, gpio, timer0
	function automatic logic [7:0] led_expect(logic gpio_mode, logic [7:0] out_byte,
		logic [3:0] bus_bits, logic [2:0] irq_bits);
		return gpio_mode ? out_byte : {bus_bits, irq_bits, 1'b0};
	endfunction

	function automatic soc_pkg::wb_dat_t gpio_in_expect(logic gpio_mode, logic [3:0] b);
		soc_pkg::wb_dat_t w;
		w = '0;
		if (gpio_mode)
			w[soc_pkg::GPIO_BTN_LSB +: 4] = b;
		return w;
	endfunction

	function automatic soc_pkg::wb_adr_t region_adr(soc_pkg::region_t region,
		soc_pkg::reg_ofs_t ofs);
		return {region, 9'b0, ofs};
	endfunction

	// ------------------------------
	// Check and report helpers
	// ------------------------------
	task automatic check_eq(string name, soc_pkg::wb_dat_t got, soc_pkg::wb_dat_t exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
		pending++;
		->cmp_ev;
	endtask

	task automatic check_max(string name, soc_pkg::wb_dat_t got, soc_pkg::wb_dat_t max_val);
		checks++;
		test_checks++;
		if ($isunknown(got) || got > max_val) begin
			errors++;
			test_errors++;
			$display("FAILED %s: got 0x%08h, limit 0x%08h", name, got, max_val);
		end
	endtask

	task automatic report_problem(string msg);
		errors++;
		test_errors++;
		$display("%s", msg);
	endtask

	task automatic start_test(string name);
		test_name   = name;
		test_errors = 0;
		test_checks = 0;
	endtask

	task automatic end_test();
		wait (pending == 0);
		$display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
	endtask

	// Drains the compare queue whenever a check is posted
	initial begin : compare_proc
		forever begin
			@(cmp_ev);
			while (got_q.size() != 0) begin
				cmp_name = name_q.pop_front();
				cmp_got  = got_q.pop_front();
				cmp_exp  = exp_q.pop_front();
				checks++;
				test_checks++;
				if (cmp_got !== cmp_exp) begin
					errors++;
					test_errors++;
					$display("FAILED %s: got 0x%08h, expected 0x%08h", cmp_name, cmp_got,
						cmp_exp);
				end
				pending--;
			end
		end
	end

	// ------------------------------
	// Bus master
	// ------------------------------
	// Request goes out on a rising edge and ack is sampled on falling edges
	task automatic bus_xfer(logic we, soc_pkg::wb_adr_t adr, soc_pkg::wb_sel_t sel,
		soc_pkg::wb_dat_t wdat, output soc_pkg::wb_dat_t rdat);
		soc_pkg::wb_req_t req;
		int               waited;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = we;
		req.adr = adr;
		req.sel = sel;
		req.dat = wdat;
		rdat    = 'x;
		waited  = 0;
		@(posedge clk);
		bus_req <= req;
		@(negedge clk);
		while (!bus_rsp.ack && waited < ACK_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (bus_rsp.ack) begin
			rdat       = bus_rsp.dat;
			led_at_ack = led;
		end else begin
			report_problem($sformatf("no ack for %s at address 0x%08h",
				we ? "write" : "read", adr));
		end
		@(posedge clk);
		bus_req <= '0;
	endtask

	task automatic bus_write(soc_pkg::wb_adr_t adr, soc_pkg::wb_sel_t sel,
		soc_pkg::wb_dat_t dat);
		soc_pkg::wb_dat_t unused;
		bus_xfer(1'b1, adr, sel, dat, unused);
	endtask

	task automatic bus_read(soc_pkg::wb_adr_t adr, output soc_pkg::wb_dat_t dat);
		bus_xfer(1'b0, adr, 4'hF, '0, dat);
	endtask

	// Board inputs followed by two edges for the GPIO input register
	task automatic drive_board(logic [3:0] sw_val, logic [3:0] btn_val);
		@(posedge clk);
		sw  <= sw_val;
		btn <= btn_val;
		repeat (2) @(posedge clk);
	endtask

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic test_reset();
		start_test("reset");
		@(negedge clk);
		check_eq("intr_n_o", intr_n, 32'hFFFF_FFFF);
		check_eq("led_o", {24'b0, led}, {24'b0, led_expect(1'b0, 8'h00, 4'h0, 3'h0)});
		check_eq("bus_rsp_o.ack", {31'b0, bus_rsp.ack}, 32'd0);
		end_test();
	endtask

	task automatic test_bram();
		int               base;
		int               k;
		soc_pkg::wb_dat_t rd;
		soc_pkg::wb_dat_t wd;
		soc_pkg::wb_dat_t rnd;
		start_test("bram");
		base = int'(lcg_next() % RAM_WORDS);
		// Full-word fill first with a pattern taken from the whole address
		for (int i = 0; i < SLOTS; i++) begin
			slot_adr[i]  = soc_pkg::wb_adr_t'(((base + i * 67) % RAM_WORDS) * 4);
			ram_model[i] = (slot_adr[i] * 32'h9E37_79B9) ^ 32'h1234_5678;
			bus_write(slot_adr[i], 4'hF, ram_model[i]);
		end
		// Overlapping partial writes
		for (int n = 0; n < RAM_WRITES; n++) begin
			k   = int'(lcg_next() % SLOTS);
			wd  = lcg_next();
			rnd = lcg_next();
			ram_model[k] = merge_lanes(ram_model[k], wd, rnd[3:0]);
			bus_write(slot_adr[k], rnd[3:0], wd);
		end
		for (int i = 0; i < SLOTS; i++) begin
			bus_read(slot_adr[i], rd);
			check_eq($sformatf("bus_rsp_o.dat @0x%08h", slot_adr[i]), rd, ram_model[i]);
		end
		end_test();
	endtask

	task automatic test_unmapped();
		soc_pkg::wb_adr_t bad_adr;
		soc_pkg::wb_dat_t rd;
		start_test("unmapped");
		// Low bits alias a RAM slot in the free region 0x1234
		bad_adr = {15'h1234, 17'b0} | slot_adr[0];
		bus_read(bad_adr, rd);
		check_eq("bus_rsp_o.dat unmapped", rd, 32'd0);
		bus_write(bad_adr, 4'hF, 32'hDEAD_BEEF);
		bus_read(bad_adr, rd);
		check_eq("bus_rsp_o.dat unmapped", rd, 32'd0);
		for (int i = 0; i < SLOTS; i++) begin
			bus_read(slot_adr[i], rd);
			check_eq($sformatf("bus_rsp_o.dat @0x%08h", slot_adr[i]), rd, ram_model[i]);
		end
		end_test();
	endtask

	task automatic test_timer_oneshot();
		soc_pkg::wb_dat_t rd;
		int               polls;
		logic             flag_seen;
		start_test("timer0_oneshot");
		bus_write(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CMP0_OFS), 4'hF,
			ONESHOT_CMP);
		bus_write(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_TCR0_OFS), 4'hF,
			tcr_expect(1'b1, 1'b0, 1'b1, 1'b0));
		polls     = 0;
		flag_seen = 1'b0;
		rd        = '0;
		while (!flag_seen && polls < MAX_POLLS) begin
			bus_read(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_TCR0_OFS), rd);
			polls++;
			flag_seen = (rd[soc_pkg::TCR_FLAG_BIT] === 1'b1);
		end
		if (!flag_seen)
			report_problem("timer 0 flag was not set within 100 control reads");
		// One-shot stops itself and holds the count
		check_eq("bus_rsp_o.dat tcr0", rd, tcr_expect(1'b0, 1'b0, 1'b1, 1'b1));
		bus_read(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CNT0_OFS), rd);
		check_eq("bus_rsp_o.dat cnt0", rd, ONESHOT_CMP);
		@(negedge clk);
		check_eq("intr_n_o[1]", {31'b0, intr_n[soc_pkg::IRQ_TIMER0]}, 32'd0);
		// Debug LEDs show timer 0 with the bus idle
		check_eq("led_o", {24'b0, led}, {24'b0, led_expect(1'b0, 8'h00, 4'h0, 3'b001)});
		// Control write with irq enable kept on clears the flag
		bus_write(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_TCR0_OFS), 4'hF,
			tcr_expect(1'b0, 1'b0, 1'b1, 1'b0));
		@(negedge clk);
		check_eq("intr_n_o[1]", {31'b0, intr_n[soc_pkg::IRQ_TIMER0]}, 32'd1);
		bus_read(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_TCR0_OFS), rd);
		check_eq("bus_rsp_o.dat tcr0", rd, tcr_expect(1'b0, 1'b0, 1'b1, 1'b0));
		end_test();
	endtask

	task automatic test_timer_reload();
		soc_pkg::wb_dat_t rd;
		int               polls;
		logic             flag_seen;
		start_test("timer1_autoreload");
		bus_write(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CMP1_OFS), 4'hF,
			RELOAD_CMP);
		bus_write(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CNT1_OFS), 4'hF, '0);
		bus_write(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_TCR1_OFS), 4'hF,
			tcr_expect(1'b1, 1'b1, 1'b1, 1'b0));
		// Spans several wraps of the counter
		for (int n = 0; n < RELOAD_READS; n++) begin
			bus_read(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CNT1_OFS), rd);
			check_max("bus_rsp_o.dat cnt1", rd, RELOAD_CMP);
		end
		bus_read(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_TCR1_OFS), rd);
		check_eq("bus_rsp_o.dat tcr1", rd, tcr_expect(1'b1, 1'b1, 1'b1, 1'b1));
		@(negedge clk);
		check_eq("intr_n_o[3]", {31'b0, intr_n[soc_pkg::IRQ_TIMER1]}, 32'd0);
		check_eq("led_o", {24'b0, led}, {24'b0, led_expect(1'b0, 8'h00, 4'h0, 3'b100)});
		// Irq enable off while the timer keeps counting up to the next hit
		bus_write(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_TCR1_OFS), 4'hF,
			tcr_expect(1'b1, 1'b1, 1'b0, 1'b0));
		polls     = 0;
		flag_seen = 1'b0;
		rd        = '0;
		while (!flag_seen && polls < MAX_POLLS) begin
			bus_read(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_TCR1_OFS), rd);
			polls++;
			flag_seen = (rd[soc_pkg::TCR_FLAG_BIT] === 1'b1);
		end
		if (!flag_seen)
			report_problem("timer 1 flag was not set again within 100 control reads");
		check_eq("bus_rsp_o.dat tcr1", rd, tcr_expect(1'b1, 1'b1, 1'b0, 1'b1));
		@(negedge clk);
		check_eq("intr_n_o[3]", {31'b0, intr_n[soc_pkg::IRQ_TIMER1]}, 32'd1);
		bus_write(region_adr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_TCR1_OFS), 4'hF, '0);
		end_test();
	endtask

	task automatic test_gpio();
		soc_pkg::wb_dat_t rd;
		soc_pkg::wb_dat_t out_val;
		soc_pkg::wb_dat_t oe_val;
		soc_pkg::wb_dat_t mask;
		soc_pkg::wb_dat_t rnd;
		logic [3:0]       btn_val;
		logic             irq_exp;
		start_test("gpio");
		rnd     = lcg_next();
		btn_val = rnd[3:0] | 4'b0001;
		drive_board(4'b0010, btn_val);
		out_val = lcg_next();
		bus_write(region_adr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OUT_OFS), 4'hF, out_val);
		@(negedge clk);
		check_eq("led_o", {24'b0, led},
			{24'b0, led_expect(1'b1, out_val[7:0], 4'h0, 3'h0)});
		bus_read(region_adr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OUT_OFS), rd);
		check_eq("bus_rsp_o.dat out", rd, out_val);
		oe_val = lcg_next();
		bus_write(region_adr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OE_OFS), 4'hF, oe_val);
		bus_read(region_adr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OE_OFS), rd);
		check_eq("bus_rsp_o.dat oe", rd, oe_val);
		bus_read(region_adr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_IN_OFS), rd);
		check_eq("bus_rsp_o.dat in", rd, gpio_in_expect(1'b1, btn_val));
		// Button 0 is always pressed
		mask = 32'd1 << soc_pkg::GPIO_BTN_LSB;
		bus_write(region_adr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_IMASK_OFS), 4'hF, mask);
		irq_exp = |(gpio_in_expect(1'b1, btn_val) & mask);
		@(negedge clk);
		check_eq("intr_n_o[2]", {31'b0, intr_n[soc_pkg::IRQ_GPIO]}, {31'b0, ~irq_exp});
		// Only released buttons unmasked
		mask = {20'b0, ~btn_val, 8'b0};
		bus_write(region_adr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_IMASK_OFS), 4'hF, mask);
		irq_exp = |(gpio_in_expect(1'b1, btn_val) & mask);
		@(negedge clk);
		check_eq("intr_n_o[2]", {31'b0, intr_n[soc_pkg::IRQ_GPIO]}, {31'b0, ~irq_exp});
		bus_read(region_adr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_IMASK_OFS), rd);
		check_eq("bus_rsp_o.dat imask", rd, mask);
		// Debug LED mode cuts the buttons off
		drive_board(4'b0000, btn_val);
		mask = 32'd1 << soc_pkg::GPIO_BTN_LSB;
		bus_write(region_adr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_IMASK_OFS), 4'hF, mask);
		// Write cycle on the debug LEDs at ack
		check_eq("led_o", {24'b0, led_at_ack},
			{24'b0, led_expect(1'b0, out_val[7:0], 4'b1111, 3'h0)});
		bus_read(region_adr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_IN_OFS), rd);
		check_eq("bus_rsp_o.dat in", rd, gpio_in_expect(1'b0, btn_val));
		check_eq("led_o", {24'b0, led_at_ack},
			{24'b0, led_expect(1'b0, out_val[7:0], 4'b1101, 3'h0)});
		irq_exp = |(gpio_in_expect(1'b0, btn_val) & mask);
		@(negedge clk);
		check_eq("intr_n_o[2]", {31'b0, intr_n[soc_pkg::IRQ_GPIO]}, {31'b0, ~irq_exp});
		// Bus idle and all interrupts quiet
		check_eq("led_o", {24'b0, led},
			{24'b0, led_expect(1'b0, out_val[7:0], 4'h0, {1'b0, irq_exp, 1'b0})});
		end_test();
	endtask

	// ------------------------------
	// Sequence and watchdog
	// ------------------------------
	initial begin : main_seq
		bus_req   <= '0;
		sw        <= '0;
		btn       <= '0;
		lcg_state = 32'd22283;
		wait (reset_i == 1'b0);
		@(posedge clk);
		test_reset();
		test_bram();
		test_unmapped();
		test_timer_oneshot();
		test_timer_reload();
		test_gpio();
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial begin : watchdog
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run stopped after %0d cycles in test %s", cycle_cnt, test_name);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
src/soc_pkg.sv
src/soc_bus_decoder.sv
src/soc_bram.sv
src/soc_timer.sv
src/soc_gpio.sv
src/soc_top.sv
tb/tb_clock.sv
tb/soc_props.sv
tb/tb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_soc_sim

verilator --binary --timing --assert -f filelist.f --top-module tb_soc \
	-Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
